// ==== list.f ====
source/tlb_pkg.sv
source/tlb_way_ram.sv
source/tlb_way_bank.sv
source/tlb_lookup.sv
source/tlb_ad_update.sv
source/tlb_top.sv
tests/tlb_tb.sv

// ==== tests/tlb_tb.sv ====
`timescale 1ns/10ps

module tlb_tb;

  localparam int AWID  = 32;
  localparam int OP_WR = 0;                      // maintenance write
  localparam int OP_RD = 1;                      // maintenance read
  localparam int OP_XL = 2;                      // translate with xlaten_i high
  localparam int OP_ID = 3;                      // idle which also ends a burst

  typedef struct packed {
    logic [1:0]  op;
    logic [1:0]  way;
    logic [9:0]  set;
    logic [63:0] dat;                            // write data or expected read data
    logic [31:0] adr;
    logic        iacc;
    logic [31:0] iadr;
    logic [7:0]  asid;
    logic        umode;
    logic        we;
    logic [31:0] e_padr;
    logic [3:0]  e_acr;
    logic        e_miss;
  } rec_t;

  logic            clk_g;
  logic            reset_i;
  logic            xlaten_i;
  logic [AWID-1:0] ladr_i;
  logic            iacc_i;
  logic [AWID-1:0] iadr_i;
  logic [7:0]      asid_i;
  logic            umode_i;
  logic            we_i;
  logic [AWID-1:0] padr_o;
  logic [3:0]      acr_o;
  logic            tlbmiss_o;
  logic            tlben_i;
  logic            wrtlb_i;
  logic [11:0]     tlbadr_i;
  logic [63:0]     tlbdat_i;
  logic [63:0]     tlbdat_o;

  rec_t        tbl [$];                          // stimulus and expected values
  logic [63:0] model [4][1024];                  // reference copy of the four ways
  logic [9:0]  s [4];                            // test sets differing in the top two bits
  logic [5:0]  t [4];                            // test tags
  logic [15:0] lfsr = 16'd27093;
  logic [31:0] last_padr = '0;                   // outputs hold on a miss
  logic [3:0]  last_acr = '0;
  logic        b_vld = 1'b0;                     // last hit of the open burst
  int          b_way;
  int          b_set;
  logic        b_we;
  logic        built = 1'b0;
  int          n_checks = 0;
  int          n_errs = 0;
  int          p1;                               // records waiting two edges for a check
  int          p2;

  tlb_top #(.AWID(AWID)) tlb_top_i (.*);

  initial begin
    clk_g = 1'b0;
    forever #10 clk_g = ~clk_g;                  // 20 ns period
  end

  // fibonacci lfsr x^16+x^14+x^13+x^11 stepped once per bit
  function automatic logic [63:0] rnd(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic logic [63:0] mk_entry(input logic [7:0] asid, input logic glb,
                                           input logic [7:0] tag);
    // asid, global, d/a clear, acr, tag, ppn (18 used bits)
    return {asid, glb, 3'b000, 4'(rnd(4)), 8'h00, tag, 6'b0, 8'h00, 18'(rnd(18))};
  endfunction

  // ==============================
  // table building with the model updated in order
  // ==============================
  task automatic add_op(input int op, input int way, input logic [9:0] set,
                        input logic [63:0] dat);
    rec_t r;
    r = '0;
    r.op  = 2'(op);
    r.way = 2'(way);
    r.set = set;
    if (op == OP_WR) model[way][set] = dat;
    r.dat = (op == OP_RD) ? model[way][set] : dat;  // read expects the model word
    tbl.push_back(r);
  endtask

  task automatic add_xl(input logic [31:0] adr, input logic iacc, input logic [7:0] asid,
                        input logic umode, input logic we);
    rec_t        r;
    logic [63:0] e;
    logic        hit;
    r = '0;
    r.op = 2'(OP_XL);
    r.adr = adr;
    r.iacc = iacc;
    r.iadr = 32'(rnd(32));
    r.asid = asid;
    r.umode = umode;
    r.we = we;
    hit = 1'b0;
    if (iacc || !umode || adr[31:24] == 8'hff) begin
      r.e_padr = iacc ? r.iadr : adr;            // untranslated with full rights
      r.e_acr  = 4'hf;
    end else begin
      for (int w = 0; w < 4; w++) begin          // first match is the lowest way
        e = model[w][adr[23:14]];
        if (!hit && e[39:32] == adr[31:24] && (e[63:56] == asid || e[55])) begin
          hit = 1'b1;
          r.e_padr = {e[17:0], adr[13:0]};
          r.e_acr = e[51:48];
          b_vld = 1'b1;
          b_way = w;
          b_set = adr[23:14];
          b_we = we;
        end
      end
      if (!hit) begin
        r.e_miss = 1'b1;
        r.e_padr = last_padr;
        r.e_acr  = last_acr;
      end
    end
    last_padr = r.e_padr;
    last_acr = r.e_acr;
    tbl.push_back(r);
  endtask

  task automatic add_kind(input int kind, input int j);
    logic [13:0] off;
    off = 14'(rnd(14));
    case (kind)
      0: add_xl({2'b00, t[j], s[j], off}, 1'b0, 8'h22, 1'b1, 1'(rnd(1)));  // ways 1,2 match
      1: add_xl({2'b00, t[j], s[j], off}, 1'b0, 8'h11, 1'b1, 1'(rnd(1)));  // way 0 only
      2: add_xl({2'b01, t[j], s[j], off}, 1'b0, 8'h33, 1'b1, 1'(rnd(1)));  // global way 3
      3: add_xl({2'b00, t[j], s[j], off}, 1'b0, 8'h33, 1'b1, 1'(rnd(1)));  // asid mismatch
      4: add_xl({8'hff, s[j], off}, 1'b0, 8'h22, 1'b1, 1'(rnd(1)));        // top 16 MiB
      5: add_xl({2'b00, t[j], s[j], off}, 1'b1, 8'h33, 1'b1, 1'(rnd(1)));  // fetch
      default: add_xl({2'b00, t[j], s[j], off}, 1'b0, 8'h33, 1'b0, 1'(rnd(1)));  // supervisor
    endcase
  endtask

  task automatic end_burst();
    if (b_vld) begin
      model[b_way][b_set][53] = 1'b1;            // accessed
      model[b_way][b_set][54] = b_we;            // dirty follows the store flag
    end
    b_vld = 1'b0;
    repeat (4) add_op(OP_ID, 0, '0, '0);         // write-back lands before port a returns
  endtask

  task automatic build_table();
    logic [9:0] rs [8];
    int         k2 [6];
    k2 = '{3, 4, 3, 5, 6, 3};
    for (int i = 0; i < 8; i++) begin
      rs[i] = 10'(rnd(10));
      add_op(OP_WR, i % 4, rs[i], rnd(64));
    end
    for (int i = 0; i < 8; i++) add_op(OP_RD, i % 4, rs[i], '0);
    for (int j = 0; j < 4; j++) begin
      s[j] = {2'(j), 8'(rnd(8))};
      t[j] = 6'(rnd(6));
      add_op(OP_WR, 0, s[j], mk_entry(8'h11, 1'b0, {2'b00, t[j]}));
      add_op(OP_WR, 1, s[j], mk_entry(8'h22, 1'b0, {2'b00, t[j]}));
      add_op(OP_WR, 2, s[j], mk_entry(8'h22, 1'b0, {2'b00, t[j]}));
      add_op(OP_WR, 3, s[j], mk_entry(8'(rnd(8)), 1'b1, {2'b01, t[j]}));
    end
    for (int i = 0; i < 14; i++) add_kind(i % 7, i % 4);  // new address every cycle
    add_kind(0, 1);                              // burst ends on a hit
    end_burst();
    for (int i = 0; i < 16; i++) add_op(OP_RD, i % 4, s[i / 4], '0);
    for (int i = 0; i < 6; i++) add_kind(k2[i], i % 4);    // no hit in this burst
    end_burst();
    for (int i = 0; i < 16; i++) add_op(OP_RD, i % 4, s[i / 4], '0);
  endtask

  // ==============================
  // drive and check
  // ==============================
  task automatic drive(input rec_t r);
    xlaten_i = (r.op == OP_XL);
    tlben_i  = (r.op == OP_WR) || (r.op == OP_RD);
    wrtlb_i  = (r.op == OP_WR);
    tlbadr_i = {r.way, r.set};
    tlbdat_i = r.dat;
    ladr_i   = r.adr;
    iacc_i   = r.iacc;
    iadr_i   = r.iadr;
    asid_i   = r.asid;
    umode_i  = r.umode;
    we_i     = r.we;
  endtask

  task automatic check_rec(input int k);
    rec_t r;
    r = tbl[k];
    n_checks++;
    if (r.op == OP_RD) begin
      assert (tlbdat_o === r.dat) else begin
        n_errs++;
        $display("Error tlbdat_o expected %h got %h (record %0d)", r.dat, tlbdat_o, k);
      end
    end else begin
      assert (tlbmiss_o === r.e_miss) else begin
        n_errs++;
        $display("Error tlbmiss_o expected %h got %h (record %0d)", r.e_miss, tlbmiss_o, k);
      end
      assert (padr_o === r.e_padr) else begin
        n_errs++;
        $display("Error padr_o expected %h got %h (record %0d)", r.e_padr, padr_o, k);
      end
      assert (acr_o === r.e_acr) else begin
        n_errs++;
        $display("Error acr_o expected %h got %h (record %0d)", r.e_acr, acr_o, k);
      end
    end
  endtask

  initial begin
    rec_t idle;
    idle = '0;
    idle.op = 2'(OP_ID);
    reset_i = 1'b1;
    drive(idle);
    build_table();
    built = 1'b1;
    repeat (5) @(posedge clk_g);                 // 5 cycles of reset
    @(negedge clk_g) reset_i = 1'b0;
    p1 = -1;
    p2 = -1;
    for (int k = 0; k < tbl.size() + 2; k++) begin
      @(negedge clk_g);
      if (p2 >= 0) check_rec(p2);                // result valid one edge after the read edge
      p2 = p1;
      p1 = (k < tbl.size() && (tbl[k].op == OP_XL || tbl[k].op == OP_RD)) ? k : -1;
      drive((k < tbl.size()) ? tbl[k] : idle);
    end
    $display("checks %0d errors %0d", n_checks, n_errs);
    if (n_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog allows ten cycles per record plus margin
  initial begin
    wait (built);
    #((tbl.size() * 10 + 100) * 20);
    $display("Timeout: the stimulus table did not complete in time");
    $display("checks %0d errors %0d", n_checks, n_errs);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== source/tlb_top.sv ====
`timescale 1ns/10ps

module tlb_top
  import tlb_pkg::*;
#(
  parameter int AWID = 32
) (
  input  logic                                     clk_g,
  input  logic                                     reset_i,
  // translation
  input  logic                                     xlaten_i,
  input  logic [AWID-1:0]                          ladr_i,
  input  logic                                     iacc_i,
  input  logic [AWID-1:0]                          iadr_i,
  input  logic [7:0]                               asid_i,
  input  logic                                     umode_i,
  input  logic                                     we_i,
  output logic [AWID-1:0]                          padr_o,
  output logic [3:0]                               acr_o,
  output logic                                     tlbmiss_o,
  // maintenance
  input  logic                                     tlben_i,
  input  logic                                     wrtlb_i,
  input  logic [TLB_WAY_SEL_BITS+TLB_SET_BITS-1:0] tlbadr_i,
  input  logic [TLB_WORD_BITS-1:0]                 tlbdat_i,
  output logic [TLB_WORD_BITS-1:0]                 tlbdat_o
);

  logic [TLB_WORD_BITS-1:0] way_rd_0;
  logic [TLB_WORD_BITS-1:0] way_rd_1;
  logic [TLB_WORD_BITS-1:0] way_rd_2;
  logic [TLB_WORD_BITS-1:0] way_rd_3;
  logic [TLB_WAYS-1:0]      hit_vec;
  logic [TLB_SET_BITS-1:0]  hit_set;
  logic [TLB_WORD_BITS-1:0] hit_entry;
  logic                     hit_we;
  logic [TLB_WAYS-1:0]      ad_we;
  logic [TLB_SET_BITS-1:0]  ad_set;
  logic [TLB_WORD_BITS-1:0] ad_data;

  // ==============================
  // storage
  // ==============================
  tlb_way_bank way_bank_i (
    .clk_g      (clk_g),
    .tlben_i    (tlben_i),
    .wrtlb_i    (wrtlb_i),
    .tlbadr_i   (tlbadr_i),
    .tlbdat_i   (tlbdat_i),
    .tlbdat_o   (tlbdat_o),
    .xlaten_i   (xlaten_i),
    .set_i      (ladr_i[TLB_TAG_LSB-1:TLB_PAGE_BITS]),   // bits 23:14
    .ad_we_i    (ad_we),
    .ad_set_i   (ad_set),
    .ad_data_i  (ad_data),
    .way_rd_0_o (way_rd_0),
    .way_rd_1_o (way_rd_1),
    .way_rd_2_o (way_rd_2),
    .way_rd_3_o (way_rd_3)
  );

  // ==============================
  // translation pipeline
  // ==============================
  tlb_lookup #(
    .AWID (AWID)
  ) lookup_i (
    .clk_g       (clk_g),
    .reset_i     (reset_i),
    .xlaten_i    (xlaten_i),
    .ladr_i      (ladr_i),
    .iacc_i      (iacc_i),
    .iadr_i      (iadr_i),
    .asid_i      (asid_i),
    .umode_i     (umode_i),
    .we_i        (we_i),
    .way_rd_0_i  (way_rd_0),
    .way_rd_1_i  (way_rd_1),
    .way_rd_2_i  (way_rd_2),
    .way_rd_3_i  (way_rd_3),
    .padr_o      (padr_o),
    .acr_o       (acr_o),
    .tlbmiss_o   (tlbmiss_o),
    .hit_vec_o   (hit_vec),
    .hit_set_o   (hit_set),
    .hit_entry_o (hit_entry),
    .hit_we_o    (hit_we)
  );

  // accessed/dirty update at the end of a burst
  tlb_ad_update #(
    .AWID (AWID)
  ) ad_update_i (
    .clk_g       (clk_g),
    .reset_i     (reset_i),
    .xlaten_i    (xlaten_i),
    .hit_vec_i   (hit_vec),
    .hit_set_i   (hit_set),
    .hit_entry_i (hit_entry),
    .hit_we_i    (hit_we),
    .ad_we_o     (ad_we),
    .ad_set_o    (ad_set),
    .ad_data_o   (ad_data)
  );

endmodule

// ==== source/tlb_ad_update.sv ====
`timescale 1ns/10ps

module tlb_ad_update
  import tlb_pkg::*;
#(
  parameter int AWID = 32
) (
  input  logic                     clk_g,
  input  logic                     reset_i,
  input  logic                     xlaten_i,
  input  logic [TLB_WAYS-1:0]      hit_vec_i,
  input  logic [TLB_SET_BITS-1:0]  hit_set_i,
  input  logic [TLB_WORD_BITS-1:0] hit_entry_i,
  input  logic                     hit_we_i,
  output logic [TLB_WAYS-1:0]      ad_we_o,
  output logic [TLB_SET_BITS-1:0]  ad_set_o,
  output logic [TLB_WORD_BITS-1:0] ad_data_o
);

  logic                    xlat_q;                 // xlaten_i one edge ago
  logic                    fall_q;                 // falling edge seen on the last edge
  logic                    cap_vld;                // a hit is held for write-back
  logic [TLB_WAYS-1:0]     cap_hit;
  logic [TLB_SET_BITS-1:0] cap_set;
  tlb_word_u               cap_word;
  logic                    cap_we;

  logic                    new_hit;
  logic                    sel_vld;
  logic [TLB_WAYS-1:0]     sel_hit;
  logic [TLB_SET_BITS-1:0] sel_set;
  tlb_word_u               sel_word;
  logic                    sel_we;
  tlb_word_u               wb_word;

  // ==============================
  // newest hit wins
  // ==============================
  // the last access of a burst reports its hit in the same cycle
  // as fall_q, so a fresh hit bypasses the capture registers
  always_comb begin
    new_hit = |hit_vec_i;
    sel_vld = new_hit | cap_vld;
    if (new_hit) begin
      sel_hit  = hit_vec_i;
      sel_set  = hit_set_i;
      sel_word = hit_entry_i;
      sel_we   = hit_we_i;
    end else begin
      sel_hit  = cap_hit;
      sel_set  = cap_set;
      sel_word = cap_word;
      sel_we   = cap_we;
    end
    wb_word = sel_word;
    wb_word.ent.accessed = 1'b1;
    wb_word.ent.dirty    = sel_we;                 // dirty only after a store
  end

  // ==============================
  // edge detect and write strobe
  // ==============================
  always_ff @(posedge clk_g) begin
    if (reset_i) begin
      xlat_q  <= 1'b0;
      fall_q  <= 1'b0;
      cap_vld <= 1'b0;
      ad_we_o <= '0;
    end else begin
      xlat_q  <= xlaten_i;
      fall_q  <= xlat_q & ~xlaten_i;
      ad_we_o <= '0;                               // single cycle strobe
      if (fall_q) begin
        ad_we_o <= sel_vld ? sel_hit : '0;         // skipped if the burst never hit
        cap_vld <= 1'b0;
      end else begin
        cap_vld <= sel_vld;
      end
    end
  end

  always_ff @(posedge clk_g) begin
    cap_hit  <= sel_hit;
    cap_set  <= sel_set;
    cap_word <= sel_word;
    cap_we   <= sel_we;
    if (fall_q) begin
      ad_set_o  <= sel_set;
      ad_data_o <= wb_word.raw;
    end
  end

endmodule

// ==== source/tlb_lookup.sv ====
`timescale 1ns/10ps

module tlb_lookup
  import tlb_pkg::*;
#(
  parameter int AWID = 32                          // 26 to 40
) (
  input  logic                     clk_g,
  input  logic                     reset_i,
  input  logic                     xlaten_i,
  input  logic [AWID-1:0]          ladr_i,
  input  logic                     iacc_i,
  input  logic [AWID-1:0]          iadr_i,
  input  logic [7:0]               asid_i,
  input  logic                     umode_i,
  input  logic                     we_i,
  input  logic [TLB_WORD_BITS-1:0] way_rd_0_i,
  input  logic [TLB_WORD_BITS-1:0] way_rd_1_i,
  input  logic [TLB_WORD_BITS-1:0] way_rd_2_i,
  input  logic [TLB_WORD_BITS-1:0] way_rd_3_i,
  output logic [AWID-1:0]          padr_o,
  output logic [3:0]               acr_o,
  output logic                     tlbmiss_o,
  output logic [TLB_WAYS-1:0]      hit_vec_o,
  output logic [TLB_SET_BITS-1:0]  hit_set_o,
  output logic [TLB_WORD_BITS-1:0] hit_entry_o,
  output logic                     hit_we_o
);

  localparam int TAG_W = AWID - TLB_TAG_LSB;      // tag bits actually compared
  localparam int PPN_W = AWID - TLB_PAGE_BITS;    // ppn bits actually used

  // stage 1, qualifiers carried beside the ram read
  logic                    s1_vld;
  logic [AWID-1:0]         s1_ladr;
  logic [AWID-1:0]         s1_iadr;
  logic                    s1_iacc;
  logic [7:0]              s1_asid;
  logic                    s1_umode;
  logic                    s1_we;

  // stage 2, compare and select
  tlb_word_u                   way_w [TLB_WAYS];
  logic [TLB_WAYS-1:0]         match;
  logic [TLB_WAY_SEL_BITS-1:0] win;              // lowest matching way
  logic [TLB_WAYS-1:0]         win_oh;
  logic                        any_hit;
  logic                        bypass;
  logic [AWID-1:0]             byp_adr;

  assign way_w[0] = way_rd_0_i;
  assign way_w[1] = way_rd_1_i;
  assign way_w[2] = way_rd_2_i;
  assign way_w[3] = way_rd_3_i;

  // ==============================
  // stage 1
  // ==============================
  always_ff @(posedge clk_g) begin
    if (reset_i) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= xlaten_i;                          // ram reads on the same edge
    end
  end

  always_ff @(posedge clk_g) begin
    if (xlaten_i) begin
      s1_ladr  <= ladr_i;
      s1_iadr  <= iadr_i;
      s1_iacc  <= iacc_i;
      s1_asid  <= asid_i;
      s1_umode <= umode_i;
      s1_we    <= we_i;
    end
  end

  // ==============================
  // stage 2 compare
  // ==============================
  always_comb begin
    // fetch, supervisor or top 16 MiB go straight through
    bypass  = s1_iacc | ~s1_umode | (&s1_ladr[AWID-1:TLB_TAG_LSB]);
    byp_adr = s1_iacc ? s1_iadr : s1_ladr;
    for (int i = 0; i < TLB_WAYS; i++) begin
      match[i] = (way_w[i].ent.tag[TAG_W-1:0] == s1_ladr[AWID-1:TLB_TAG_LSB]) &&
                 ((way_w[i].ent.asid == s1_asid) || way_w[i].ent.glb);
    end
    any_hit = |match;
    win     = '0;
    for (int i = TLB_WAYS - 1; i >= 0; i--) begin  // walk down so way 0 wins last
      if (match[i]) begin
        win = TLB_WAY_SEL_BITS'(i);
      end
    end
    win_oh = any_hit ? (TLB_WAYS'(1) << win) : '0;
  end

  // ==============================
  // stage 2 outputs
  // ==============================
  always_ff @(posedge clk_g) begin
    if (reset_i) begin
      tlbmiss_o <= 1'b0;
      acr_o     <= 4'h0;
      hit_vec_o <= '0;
    end else if (s1_vld) begin
      if (bypass) begin
        tlbmiss_o <= 1'b0;
        acr_o     <= TLB_ACR_ALL;
        hit_vec_o <= '0;                           // nothing to write back
      end else if (any_hit) begin
        tlbmiss_o <= 1'b0;
        acr_o     <= way_w[win].ent.acr;
        hit_vec_o <= win_oh;
      end else begin
        tlbmiss_o <= 1'b1;                         // padr_o and acr_o keep old values
        hit_vec_o <= '0;
      end
    end else begin
      hit_vec_o <= '0;                             // one pulse per translated hit
    end
  end

  always_ff @(posedge clk_g) begin
    if (s1_vld) begin
      if (bypass) begin
        padr_o <= byp_adr;
      end else if (any_hit) begin
        padr_o <= {way_w[win].ent.ppn[PPN_W-1:0], s1_ladr[TLB_PAGE_BITS-1:0]};
      end
      hit_set_o   <= s1_ladr[TLB_TAG_LSB-1:TLB_PAGE_BITS];   // set this access read
      hit_entry_o <= way_w[win].raw;
      hit_we_o    <= s1_we;
    end
  end

endmodule

// ==== source/tlb_way_bank.sv ====
`timescale 1ns/10ps

module tlb_way_bank
  import tlb_pkg::*;
(
  input  logic                                   clk_g,
  // maintenance
  input  logic                                   tlben_i,
  input  logic                                   wrtlb_i,
  input  logic [TLB_WAY_SEL_BITS+TLB_SET_BITS-1:0] tlbadr_i,
  input  logic [TLB_WORD_BITS-1:0]               tlbdat_i,
  output logic [TLB_WORD_BITS-1:0]               tlbdat_o,
  // translation read
  input  logic                                   xlaten_i,
  input  logic [TLB_SET_BITS-1:0]                set_i,
  // accessed/dirty write-back
  input  logic [TLB_WAYS-1:0]                    ad_we_i,
  input  logic [TLB_SET_BITS-1:0]                ad_set_i,
  input  logic [TLB_WORD_BITS-1:0]               ad_data_i,
  // entries read on port b
  output logic [TLB_WORD_BITS-1:0]               way_rd_0_o,
  output logic [TLB_WORD_BITS-1:0]               way_rd_1_o,
  output logic [TLB_WORD_BITS-1:0]               way_rd_2_o,
  output logic [TLB_WORD_BITS-1:0]               way_rd_3_o
);

  logic [TLB_WAY_SEL_BITS-1:0] mnt_way;            // way field of tlbadr_i
  logic [TLB_SET_BITS-1:0]     mnt_set;            // set field of tlbadr_i
  logic                        mnt_rd;             // maintenance read strobe
  logic [TLB_WAY_SEL_BITS-1:0] rd_way_q;           // way read on the last read edge
  logic                        rd_q;               // a read happened on the last edge
  logic                        b_wr;               // write-back owns port b
  logic                        b_en;
  logic [TLB_SET_BITS-1:0]     b_addr;
  logic [TLB_WORD_BITS-1:0]    a_dout [TLB_WAYS];
  logic [TLB_WORD_BITS-1:0]    b_dout [TLB_WAYS];

  assign mnt_way = tlbadr_i[TLB_SET_BITS +: TLB_WAY_SEL_BITS];  // bits 11:10
  assign mnt_set = tlbadr_i[TLB_SET_BITS-1:0];                  // bits 9:0
  assign mnt_rd  = tlben_i & ~wrtlb_i;

  assign b_wr   = |ad_we_i;
  assign b_en   = xlaten_i | b_wr;
  assign b_addr = b_wr ? ad_set_i : set_i;         // write-back steals the port

  // ==============================
  // four ways
  // ==============================
  for (genvar g = 0; g < TLB_WAYS; g++) begin : g_way
    tlb_way_ram way_ram_i (
      .clk_g    (clk_g),
      .a_en_i   (tlben_i),                                      // every way reads
      .a_we_i   (wrtlb_i && (mnt_way == TLB_WAY_SEL_BITS'(g))), // only the addressed way writes
      .a_addr_i (mnt_set),
      .a_din_i  (tlbdat_i),
      .a_dout_o (a_dout[g]),
      .b_en_i   (b_en),
      .b_we_i   (ad_we_i[g]),
      .b_addr_i (b_addr),
      .b_din_i  (ad_data_i),
      .b_dout_o (b_dout[g])
    );
  end

  assign way_rd_0_o = b_dout[0];
  assign way_rd_1_o = b_dout[1];
  assign way_rd_2_o = b_dout[2];
  assign way_rd_3_o = b_dout[3];

  // ==============================
  // maintenance read data
  // ==============================
  // ram output is valid after the read edge, tlbdat_o one edge later
  always_ff @(posedge clk_g) begin
    rd_q <= mnt_rd;
    if (mnt_rd) begin
      rd_way_q <= mnt_way;                         // remember which way to show
    end
    if (rd_q) begin
      tlbdat_o <= a_dout[rd_way_q];                // held until the next read
    end
  end

endmodule

// ==== source/tlb_way_ram.sv ====
`timescale 1ns/10ps

module tlb_way_ram
  import tlb_pkg::*;
(
  input  logic                     clk_g,
  // port a, maintenance
  input  logic                     a_en_i,
  input  logic                     a_we_i,
  input  logic [TLB_SET_BITS-1:0]  a_addr_i,
  input  logic [TLB_WORD_BITS-1:0] a_din_i,
  output logic [TLB_WORD_BITS-1:0] a_dout_o,
  // port b, translation and write-back
  input  logic                     b_en_i,
  input  logic                     b_we_i,
  input  logic [TLB_SET_BITS-1:0]  b_addr_i,
  input  logic [TLB_WORD_BITS-1:0] b_din_i,
  output logic [TLB_WORD_BITS-1:0] b_dout_o
);

  localparam int DEPTH = 2 ** TLB_SET_BITS;

  logic [TLB_WORD_BITS-1:0] mem [DEPTH];  // contents not reset

  // ==============================
  // port a
  // ==============================
  always @(posedge clk_g) begin
    if (a_en_i) begin
      a_dout_o <= mem[a_addr_i];          // old data on a write cycle
      if (a_we_i) begin
        mem[a_addr_i] <= a_din_i;
      end
    end
  end

  // ==============================
  // port b
  // ==============================
  always @(posedge clk_g) begin
    if (b_en_i) begin
      b_dout_o <= mem[b_addr_i];          // read-before-write like port a
      if (b_we_i) begin
        mem[b_addr_i] <= b_din_i;
      end
    end
  end

  // both ports share one array, so the two processes
  // must never hit the same address together

endmodule

// ==== source/tlb_pkg.sv ====
package tlb_pkg;

  // ==============================
  // tlb geometry
  // ==============================
  localparam int TLB_WAYS         = 4;      // ways searched in parallel
  localparam int TLB_SET_BITS     = 10;     // 1024 sets per way
  localparam int TLB_PAGE_BITS    = 14;     // 16 KiB pages
  localparam int TLB_WAY_SEL_BITS = 2;      // way field in maintenance address
  localparam int TLB_WORD_BITS    = 64;     // one entry per ram word

  // lowest virtual address bit above the set index, start of the tag
  localparam int TLB_TAG_LSB = TLB_PAGE_BITS + TLB_SET_BITS;

  localparam logic [3:0] TLB_ACR_ALL = 4'b1111;  // rights given to bypassed accesses

  // ==============================
  // entry layout
  // ==============================
  typedef struct packed {
    logic [7:0]  asid;       // 63:56 address space id
    logic        glb;        // 55 global page, ignores asid
    logic        dirty;      // 54 set by write-back on a store
    logic        accessed;   // 53 set by write-back on any hit
    logic        rsv_52;     // 52 spare
    logic [3:0]  acr;        // 51:48 access rights code
    logic [15:0] tag;        // 47:32 low AWID-24 bits compared
    logic [5:0]  rsv_31_26;  // 31:26 spare
    logic [25:0] ppn;        // 25:0 low AWID-14 bits used
  } tlb_entry_t;

  // raw word for the ram and maintenance side, fields for lookup and write-back
  typedef union packed {
    logic [TLB_WORD_BITS-1:0] raw;
    tlb_entry_t               ent;
  } tlb_word_u;

endpackage
